// ==== build.f ====
kernel_cu_pkg.sv
cu_setup_reader.sv
vertex_reduce_engine.sv
memory_arbiter.sv
kernel_cu.sv
tb_wb_memory.sv
tb_kernel_cu.sv

// ==== cu_setup_reader.sv ====
// Setup reader for the graph compute unit
// Descriptor intake, configuration word fetch, opcode check and done/error

`timescale 1ns/1ps

module cu_setup_reader #(
  parameter int ADDR_WIDTH = kernel_cu_pkg::DEFAULT_ADDR_WIDTH,
  parameter int DATA_WIDTH = kernel_cu_pkg::DEFAULT_DATA_WIDTH
) (
  input  logic                                   ap_clk,
  input  logic                                   areset_control,
  // Descriptor
  input  logic                                   desc_valid,
  output logic                                   desc_ready,
  input  logic [ADDR_WIDTH-1:0]                  desc_config_addr,
  input  logic [ADDR_WIDTH-1:0]                  desc_vertex_addr,
  input  logic [ADDR_WIDTH-1:0]                  desc_result_addr,
  // Read-only memory port toward the arbiter
  output logic                                   setup_cyc,
  output logic                                   setup_stb,
  output logic [ADDR_WIDTH-1:0]                  setup_adr,
  input  logic [DATA_WIDTH-1:0]                  setup_dat_r,
  input  logic                                   setup_ack,
  // Engine control
  output logic                                   start,
  output kernel_cu_pkg::reduce_op_e              op,
  output logic [kernel_cu_pkg::COUNT_WIDTH-1:0]  count,
  output logic [ADDR_WIDTH-1:0]                  vertex_addr,
  output logic [ADDR_WIDTH-1:0]                  result_addr,
  input  logic                                   finished,
  // Completion
  output logic                                   done,
  output logic                                   error
);

  kernel_cu_pkg::setup_state_e state;
  logic [ADDR_WIDTH-1:0]       config_addr_q;
  logic [1:0]                  opcode_field;
  logic                        accept;

  assign accept       = desc_valid & desc_ready;
  assign opcode_field = setup_dat_r[kernel_cu_pkg::OPCODE_LSB +: 2];

  // Single read in flight, held for the whole fetch
  assign setup_cyc = (state == kernel_cu_pkg::SETUP_FETCH);
  assign setup_stb = setup_cyc;
  assign setup_adr = config_addr_q;

  // --------------------------------------------------------------------
  // Control FSM
  // --------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state      <= kernel_cu_pkg::SETUP_IDLE;
      desc_ready <= 1'b1;
      start      <= 1'b0;
      done       <= 1'b0;
      error      <= 1'b0;
    end else begin
      // Pulses by default
      start <= 1'b0;
      done  <= 1'b0;
      error <= 1'b0;
      case (state)
        kernel_cu_pkg::SETUP_IDLE: begin
          if (accept) begin
            state      <= kernel_cu_pkg::SETUP_FETCH;
            desc_ready <= 1'b0;
          end
        end
        kernel_cu_pkg::SETUP_FETCH: begin
          if (setup_ack) begin
            if (opcode_field == 2'd3) begin
              // Bad opcode, finish here and leave the engine idle
              done  <= 1'b1;
              error <= 1'b1;
              state <= kernel_cu_pkg::SETUP_IDLE;
            end else begin
              start <= 1'b1;
              state <= kernel_cu_pkg::SETUP_RUN;
            end
          end
        end
        kernel_cu_pkg::SETUP_RUN: begin
          if (finished) begin
            done  <= 1'b1;
            state <= kernel_cu_pkg::SETUP_IDLE;
          end
        end
        default: state <= kernel_cu_pkg::SETUP_IDLE;
      endcase
      // Ready again one cycle after done
      if (done) begin
        desc_ready <= 1'b1;
      end
    end
  end

  // Descriptor and configuration fields
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      config_addr_q <= desc_config_addr;
      vertex_addr   <= desc_vertex_addr;
      result_addr   <= desc_result_addr;
    end
    if (setup_cyc && setup_ack) begin
      op    <= kernel_cu_pkg::reduce_op_e'(opcode_field);
      count <= setup_dat_r[kernel_cu_pkg::COUNT_WIDTH-1:0];
    end
  end

  // Engine is only launched by a completed configuration fetch
  assert property (@(posedge ap_clk) disable iff (areset_control)
    start |-> $past(state == kernel_cu_pkg::SETUP_FETCH))
    else $error("start pulsed without a configuration fetch");

endmodule : cu_setup_reader

// ==== kernel_cu.sv ====
// Top level of the graph compute unit
// Setup reader, vertex engine and memory arbiter with their wiring

`timescale 1ns/1ps

module kernel_cu #(
  parameter int ADDR_WIDTH = kernel_cu_pkg::DEFAULT_ADDR_WIDTH,
  parameter int DATA_WIDTH = kernel_cu_pkg::DEFAULT_DATA_WIDTH
) (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  // Descriptor
  input  logic                  desc_valid,
  output logic                  desc_ready,
  input  logic [ADDR_WIDTH-1:0] desc_config_addr,
  input  logic [ADDR_WIDTH-1:0] desc_vertex_addr,
  input  logic [ADDR_WIDTH-1:0] desc_result_addr,
  // Completion
  output logic                  done,
  output logic                  error,
  // Wishbone memory
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [ADDR_WIDTH-1:0] wb_adr,
  output logic [DATA_WIDTH-1:0] wb_dat_w,
  input  logic [DATA_WIDTH-1:0] wb_dat_r,
  input  logic                  wb_ack
);

  // --------------------------------------------------------------------
  // Setup reader to arbiter
  // --------------------------------------------------------------------
  logic                  setup_cyc;
  logic                  setup_stb;
  logic [ADDR_WIDTH-1:0] setup_adr;
  logic [DATA_WIDTH-1:0] setup_dat_r;
  logic                  setup_ack;

  // Engine to arbiter
  logic                  eng_cyc;
  logic                  eng_stb;
  logic                  eng_we;
  logic [ADDR_WIDTH-1:0] eng_adr;
  logic [DATA_WIDTH-1:0] eng_dat_w;
  logic [DATA_WIDTH-1:0] eng_dat_r;
  logic                  eng_ack;

  // Setup reader to engine
  logic                                  start;
  kernel_cu_pkg::reduce_op_e             op;
  logic [kernel_cu_pkg::COUNT_WIDTH-1:0] count;
  logic [ADDR_WIDTH-1:0]                 vertex_addr;
  logic [ADDR_WIDTH-1:0]                 result_addr;
  logic                                  finished;

  cu_setup_reader #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) inst_cu_setup_reader (
    .ap_clk          (ap_clk          ),
    .areset_control  (areset_control  ),
    .desc_valid      (desc_valid      ),
    .desc_ready      (desc_ready      ),
    .desc_config_addr(desc_config_addr),
    .desc_vertex_addr(desc_vertex_addr),
    .desc_result_addr(desc_result_addr),
    .setup_cyc       (setup_cyc       ),
    .setup_stb       (setup_stb       ),
    .setup_adr       (setup_adr       ),
    .setup_dat_r     (setup_dat_r     ),
    .setup_ack       (setup_ack       ),
    .start           (start           ),
    .op              (op              ),
    .count           (count           ),
    .vertex_addr     (vertex_addr     ),
    .result_addr     (result_addr     ),
    .finished        (finished        ),
    .done            (done            ),
    .error           (error           )
  );

  vertex_reduce_engine #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) inst_vertex_reduce_engine (
    .ap_clk        (ap_clk        ),
    .areset_control(areset_control),
    .start         (start         ),
    .op            (op            ),
    .count         (count         ),
    .vertex_addr   (vertex_addr   ),
    .result_addr   (result_addr   ),
    .eng_cyc       (eng_cyc       ),
    .eng_stb       (eng_stb       ),
    .eng_we        (eng_we        ),
    .eng_adr       (eng_adr       ),
    .eng_dat_w     (eng_dat_w     ),
    .eng_dat_r     (eng_dat_r     ),
    .eng_ack       (eng_ack       ),
    .finished      (finished      )
  );

  memory_arbiter #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) inst_memory_arbiter (
    .ap_clk        (ap_clk        ),
    .areset_control(areset_control),
    .setup_cyc     (setup_cyc     ),
    .setup_stb     (setup_stb     ),
    .setup_adr     (setup_adr     ),
    .setup_dat_r   (setup_dat_r   ),
    .setup_ack     (setup_ack     ),
    .eng_cyc       (eng_cyc       ),
    .eng_stb       (eng_stb       ),
    .eng_we        (eng_we        ),
    .eng_adr       (eng_adr       ),
    .eng_dat_w     (eng_dat_w     ),
    .eng_dat_r     (eng_dat_r     ),
    .eng_ack       (eng_ack       ),
    .wb_cyc        (wb_cyc        ),
    .wb_stb        (wb_stb        ),
    .wb_we         (wb_we         ),
    .wb_adr        (wb_adr        ),
    .wb_dat_w      (wb_dat_w      ),
    .wb_dat_r      (wb_dat_r      ),
    .wb_ack        (wb_ack        )
  );

endmodule : kernel_cu

// ==== kernel_cu_pkg.sv ====
// Shared definitions for the graph compute unit
// Default widths, configuration word fields, opcode and FSM state enums

package kernel_cu_pkg;

  // --------------------------------------------------------------------
  // Default widths
  // --------------------------------------------------------------------
  localparam int DEFAULT_ADDR_WIDTH = 16;
  localparam int DEFAULT_DATA_WIDTH = 32;

  // Configuration word layout
  // Vertex count sits in the low bits
  localparam int COUNT_WIDTH = 16;
  // Two opcode bits right above the count
  localparam int OPCODE_LSB  = 16;

  // --------------------------------------------------------------------
  // Reduction opcodes, encoding 3 is rejected by the setup reader
  // --------------------------------------------------------------------
  typedef enum logic [1:0] {
    OP_SUM      = 2'd0,
    OP_MAX      = 2'd1,
    OP_COUNT_NZ = 2'd2
  } reduce_op_e;

  // Setup reader FSM
  typedef enum logic [1:0] {
    SETUP_IDLE,
    SETUP_FETCH,
    SETUP_RUN
  } setup_state_e;

  // Vertex engine FSM
  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_READ,
    ENG_WRITE,
    ENG_DONE
  } engine_state_e;

endpackage : kernel_cu_pkg

// ==== memory_arbiter.sv ====
// Round-robin arbiter between the setup reader and the vertex engine
// External Wishbone classic master and registered response routing

`timescale 1ns/1ps

module memory_arbiter #(
  parameter int ADDR_WIDTH = kernel_cu_pkg::DEFAULT_ADDR_WIDTH,
  parameter int DATA_WIDTH = kernel_cu_pkg::DEFAULT_DATA_WIDTH
) (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  // Setup reader, read only
  input  logic                  setup_cyc,
  input  logic                  setup_stb,
  input  logic [ADDR_WIDTH-1:0] setup_adr,
  output logic [DATA_WIDTH-1:0] setup_dat_r,
  output logic                  setup_ack,
  // Vertex engine
  input  logic                  eng_cyc,
  input  logic                  eng_stb,
  input  logic                  eng_we,
  input  logic [ADDR_WIDTH-1:0] eng_adr,
  input  logic [DATA_WIDTH-1:0] eng_dat_w,
  output logic [DATA_WIDTH-1:0] eng_dat_r,
  output logic                  eng_ack,
  // External Wishbone master
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [ADDR_WIDTH-1:0] wb_adr,
  output logic [DATA_WIDTH-1:0] wb_dat_w,
  input  logic [DATA_WIDTH-1:0] wb_dat_r,
  input  logic                  wb_ack
);

  logic                  setup_req;
  logic                  eng_req;
  logic                  grant_eng;
  logic                  can_grant;
  logic                  owner_eng;
  logic                  prio_eng;
  logic [DATA_WIDTH-1:0] ack_dat;

  assign setup_req = setup_cyc & setup_stb;
  assign eng_req   = eng_cyc & eng_stb;
  // Wait out the routed ack, the owner still holds its request then
  assign can_grant = ~wb_cyc & ~setup_ack & ~eng_ack;
  // Engine wins when alone or when it holds the priority
  assign grant_eng = eng_req & (~setup_req | prio_eng);

  // Read data goes back to the owner only
  assign setup_dat_r = setup_ack ? ack_dat : '0;
  assign eng_dat_r   = eng_ack ? ack_dat : '0;

  // --------------------------------------------------------------------
  // Grant, external cycle and ack routing
  // --------------------------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wb_cyc    <= 1'b0;
      wb_stb    <= 1'b0;
      wb_we     <= 1'b0;
      owner_eng <= 1'b0;
      prio_eng  <= 1'b0;
      setup_ack <= 1'b0;
      eng_ack   <= 1'b0;
    end else begin
      setup_ack <= 1'b0;
      eng_ack   <= 1'b0;
      if (wb_cyc) begin
        if (wb_ack) begin
          // Release the bus, ack the owner next cycle
          wb_cyc    <= 1'b0;
          wb_stb    <= 1'b0;
          wb_we     <= 1'b0;
          setup_ack <= ~owner_eng;
          eng_ack   <= owner_eng;
        end
      end else if (can_grant && (setup_req || eng_req)) begin
        wb_cyc    <= 1'b1;
        wb_stb    <= 1'b1;
        wb_we     <= grant_eng & eng_we;
        owner_eng <= grant_eng;
        // Loser of this round goes first next time
        prio_eng  <= ~grant_eng;
      end
    end
  end

  // Address, write data and captured read data
  always_ff @(posedge ap_clk) begin
    if (can_grant) begin
      wb_adr   <= grant_eng ? eng_adr : setup_adr;
      wb_dat_w <= eng_dat_w;
    end
    if (wb_cyc && wb_ack) begin
      ack_dat <= wb_dat_r;
    end
  end

  assert property (@(posedge ap_clk) disable iff (areset_control)
    wb_stb |-> wb_cyc)
    else $error("wb_stb without wb_cyc");

  // Responses never fan out to both requestors
  assert property (@(posedge ap_clk) disable iff (areset_control)
    $onehot0({setup_ack, eng_ack}))
    else $error("ack routed to both requestors");

endmodule : memory_arbiter

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the compute unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_kernel_cu
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f build.f \
  --top-module tb_kernel_cu \
  -Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Simulation finished: PASS" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== tb_kernel_cu.sv ====
// Testbench for the graph compute unit
// Clock, reset, descriptor stimulus, LFSR data, assertions, timeout, report

`timescale 1ns/1ps

module tb_kernel_cu;

  localparam int          ADDR_WIDTH     = kernel_cu_pkg::DEFAULT_ADDR_WIDTH;
  localparam int          DATA_WIDTH     = kernel_cu_pkg::DEFAULT_DATA_WIDTH;
  localparam int          CLK_PERIOD     = 40;
  localparam logic [31:0] SEED           = 32'd79601;
  // Vertices of the sum, max, count, empty and bad opcode runs
  localparam int          TOTAL_VERTICES = 12 + 10 + 16 + 0 + 4;
  localparam int          CYCLE_LIMIT    = TOTAL_VERTICES * 8 + 200;

  logic                  ap_clk;
  logic                  areset_control;
  logic                  desc_valid;
  logic                  desc_ready;
  logic [ADDR_WIDTH-1:0] desc_config_addr;
  logic [ADDR_WIDTH-1:0] desc_vertex_addr;
  logic [ADDR_WIDTH-1:0] desc_result_addr;
  logic                  done;
  logic                  error;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [ADDR_WIDTH-1:0] wb_adr;
  logic [DATA_WIDTH-1:0] wb_dat_w;
  logic [DATA_WIDTH-1:0] wb_dat_r;
  logic                  wb_ack;
  // Memory preload and read-back
  logic                  load_en;
  logic [ADDR_WIDTH-1:0] load_adr;
  logic [DATA_WIDTH-1:0] load_dat;
  logic [ADDR_WIDTH-1:0] peek_adr;
  logic [DATA_WIDTH-1:0] peek_dat;
  // Expectations for the descriptor in flight
  logic [DATA_WIDTH-1:0] expected_result;
  logic                  expect_error;
  logic                  bad_op_run;
  logic [31:0]           lfsr_state;
  int                    outstanding;
  int                    done_count;
  int                    descriptors_run;
  int                    cycle_count;
  int                    value_errors;
  int                    protocol_errors;
  int                    end_errors;

  kernel_cu #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) UUT (
    .ap_clk          (ap_clk          ),
    .areset_control  (areset_control  ),
    .desc_valid      (desc_valid      ),
    .desc_ready      (desc_ready      ),
    .desc_config_addr(desc_config_addr),
    .desc_vertex_addr(desc_vertex_addr),
    .desc_result_addr(desc_result_addr),
    .done            (done            ),
    .error           (error           ),
    .wb_cyc          (wb_cyc          ),
    .wb_stb          (wb_stb          ),
    .wb_we           (wb_we           ),
    .wb_adr          (wb_adr          ),
    .wb_dat_w        (wb_dat_w        ),
    .wb_dat_r        (wb_dat_r        ),
    .wb_ack          (wb_ack          )
  );

  tb_wb_memory #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH),
    .DEPTH     (1024      ),
    .SEED      (SEED      )
  ) inst_tb_wb_memory (
    .ap_clk        (ap_clk        ),
    .areset_control(areset_control),
    .wb_cyc        (wb_cyc        ),
    .wb_stb        (wb_stb        ),
    .wb_we         (wb_we         ),
    .wb_adr        (wb_adr        ),
    .wb_dat_w      (wb_dat_w      ),
    .wb_dat_r      (wb_dat_r      ),
    .wb_ack        (wb_ack        ),
    .load_en       (load_en       ),
    .load_adr      (load_adr      ),
    .load_dat      (load_dat      ),
    .peek_adr      (peek_adr      ),
    .peek_dat      (peek_dat      )
  );

  initial begin
    ap_clk = 1'b0;
    forever #(CLK_PERIOD / 2) ap_clk = ~ap_clk;
  end

  // --------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------
  // Result word at done
  // A bad opcode leaves the sentinel in place
  assert property (@(posedge ap_clk) disable iff (areset_control)
    done |-> (peek_dat == expected_result))
    else begin
      value_errors++;
      $display("Fail at %0t: result 0x%08h, expected 0x%08h", $time, peek_dat,
               expected_result);
    end

  assert property (@(posedge ap_clk) disable iff (areset_control)
    done |-> (error == expect_error))
    else begin
      value_errors++;
      $display("Fail at %0t: error flag %0b, expected %0b", $time, error, expect_error);
    end

  // A rejected opcode never reaches the write path
  assert property (@(posedge ap_clk) disable iff (areset_control)
    bad_op_run |-> !wb_we)
    else begin
      protocol_errors++;
      $display("Memory write seen during a bad-opcode descriptor at %0t", $time);
    end

  // Idle outputs right after reset
  assert property (@(posedge ap_clk)
    $fell(areset_control) |-> (desc_ready && !wb_cyc && !done && !error))
    else begin
      protocol_errors++;
      $display("Outputs not idle after reset at %0t", $time);
    end

  assert property (@(posedge ap_clk) disable iff (areset_control)
    (desc_valid && desc_ready) |=> !desc_ready)
    else begin
      protocol_errors++;
      $display("desc_ready stayed high after a descriptor was taken at %0t", $time);
    end

  assert property (@(posedge ap_clk) disable iff (areset_control)
    done |=> desc_ready)
    else begin
      protocol_errors++;
      $display("desc_ready did not return after done at %0t", $time);
    end

  // One done per accepted descriptor
  assert property (@(posedge ap_clk) disable iff (areset_control)
    done |-> (outstanding == 1))
    else begin
      protocol_errors++;
      $display("done without exactly one descriptor in flight at %0t", $time);
    end

  assert property (@(posedge ap_clk) disable iff (areset_control)
    (desc_valid && desc_ready) |-> (outstanding == 0))
    else begin
      protocol_errors++;
      $display("Descriptor taken while another was in flight at %0t", $time);
    end

  always @(posedge ap_clk) begin
    if (areset_control) begin
      outstanding <= 0;
      done_count  <= 0;
    end else begin
      if (desc_valid && desc_ready) begin
        outstanding <= outstanding + 1;
      end else if (done) begin
        outstanding <= outstanding - 1;
      end
      if (done) begin
        done_count <= done_count + 1;
      end
    end
  end

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge ap_clk);
      cycle_count++;
    end
    $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // One LFSR step per bit
  task automatic draw_bits(input int n, output logic [DATA_WIDTH-1:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value      = {value[DATA_WIDTH-2:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic load_word(input logic [ADDR_WIDTH-1:0] adr, input logic [DATA_WIDTH-1:0] dat);
    @(posedge ap_clk);
    load_en  <= 1'b1;
    load_adr <= adr;
    load_dat <= dat;
  endtask

  task automatic run_descriptor(input logic [ADDR_WIDTH-1:0] cfg_adr,
                                input logic [ADDR_WIDTH-1:0] vtx_adr,
                                input logic [ADDR_WIDTH-1:0] res_adr);
    @(posedge ap_clk);
    desc_valid       <= 1'b1;
    desc_config_addr <= cfg_adr;
    desc_vertex_addr <= vtx_adr;
    desc_result_addr <= res_adr;
    do @(posedge ap_clk); while (!(desc_valid && desc_ready));
    descriptors_run++;
    // Junk descriptor held while busy
    desc_config_addr <= ADDR_WIDTH'(16'h03f0);
    desc_vertex_addr <= ADDR_WIDTH'(16'h0300);
    desc_result_addr <= ADDR_WIDTH'(16'h03f8);
    do @(posedge ap_clk); while (!done);
    desc_valid <= 1'b0;
    bad_op_run <= 1'b0;
  endtask

  // Fill config, vertices and result sentinel and run one descriptor
  task automatic reduce_test(input int t, input logic [1:0] opcode, input int n,
                             input logic sparse);
    logic [ADDR_WIDTH-1:0] cfg_adr;
    logic [ADDR_WIDTH-1:0] vtx_adr;
    logic [ADDR_WIDTH-1:0] res_adr;
    logic [DATA_WIDTH-1:0] cfg_word;
    logic [DATA_WIDTH-1:0] word;
    logic [DATA_WIDTH-1:0] keep;
    logic [DATA_WIDTH-1:0] exp_word;
    cfg_adr  = ADDR_WIDTH'(16 + t);
    vtx_adr  = ADDR_WIDTH'(256 + 64 * t);
    res_adr  = ADDR_WIDTH'(512 + t);
    cfg_word = '0;
    cfg_word[kernel_cu_pkg::COUNT_WIDTH-1:0] = kernel_cu_pkg::COUNT_WIDTH'(n);
    cfg_word[kernel_cu_pkg::OPCODE_LSB +: 2] = opcode;
    load_word(cfg_adr, cfg_word);
    exp_word = '0;
    for (int i = 0; i < n; i++) begin
      draw_bits(DATA_WIDTH, word);
      if (sparse) begin
        draw_bits(1, keep);
        if (keep == '0) begin
          word = '0;
        end
      end
      case (opcode)
        kernel_cu_pkg::OP_MAX: begin
          if (word > exp_word) begin
            exp_word = word;
          end
        end
        kernel_cu_pkg::OP_COUNT_NZ: begin
          if (word != '0) begin
            exp_word = exp_word + 1;
          end
        end
        default: exp_word = exp_word + word;
      endcase
      load_word(vtx_adr + ADDR_WIDTH'(i), word);
    end
    // Sentinel made from the result address
    load_word(res_adr, DATA_WIDTH'({~res_adr, res_adr}));
    if (opcode == 2'd3) begin
      exp_word = DATA_WIDTH'({~res_adr, res_adr});
    end
    @(posedge ap_clk);
    load_en         <= 1'b0;
    expected_result <= exp_word;
    expect_error    <= (opcode == 2'd3);
    bad_op_run      <= (opcode == 2'd3);
    peek_adr        <= res_adr;
    run_descriptor(cfg_adr, vtx_adr, res_adr);
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial begin
    areset_control   = 1'b1;
    desc_valid       = 1'b0;
    desc_config_addr = '0;
    desc_vertex_addr = '0;
    desc_result_addr = '0;
    load_en          = 1'b0;
    load_adr         = '0;
    load_dat         = '0;
    peek_adr         = '0;
    expected_result  = '0;
    expect_error     = 1'b0;
    bad_op_run       = 1'b0;
    lfsr_state       = SEED;
    descriptors_run  = 0;
    value_errors     = 0;
    protocol_errors  = 0;
    end_errors       = 0;
    repeat (4) @(posedge ap_clk);
    areset_control <= 1'b0;
    reduce_test(0, kernel_cu_pkg::OP_SUM, 12, 1'b0);
    reduce_test(1, kernel_cu_pkg::OP_MAX, 10, 1'b0);
    reduce_test(2, kernel_cu_pkg::OP_COUNT_NZ, 16, 1'b1);
    reduce_test(3, kernel_cu_pkg::OP_SUM, 0, 1'b0);
    reduce_test(4, 2'd3, 4, 1'b0);
    repeat (4) @(posedge ap_clk);
    if (outstanding != 0 || done_count != descriptors_run) begin
      end_errors++;
      $display("Saw %0d done pulses for %0d accepted descriptors", done_count,
               descriptors_run);
    end
    $display("Errors: %0d value, %0d protocol, %0d end of run", value_errors,
             protocol_errors, end_errors);
    if (value_errors + protocol_errors + end_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule : tb_kernel_cu

// ==== tb_wb_memory.sv ====
// Testbench Wishbone classic slave memory
// Word array with a load port, a peek port and LFSR-driven ack delays

`timescale 1ns/1ps

module tb_wb_memory #(
  parameter int          ADDR_WIDTH = kernel_cu_pkg::DEFAULT_ADDR_WIDTH,
  parameter int          DATA_WIDTH = kernel_cu_pkg::DEFAULT_DATA_WIDTH,
  parameter int          DEPTH      = 1024,
  parameter logic [31:0] SEED       = 32'd79601
) (
  input  logic                  ap_clk,
  input  logic                  areset_control,
  // Wishbone slave side
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [ADDR_WIDTH-1:0] wb_adr,
  input  logic [DATA_WIDTH-1:0] wb_dat_w,
  output logic [DATA_WIDTH-1:0] wb_dat_r,
  output logic                  wb_ack,
  // Preload, one word per cycle
  input  logic                  load_en,
  input  logic [ADDR_WIDTH-1:0] load_adr,
  input  logic [DATA_WIDTH-1:0] load_dat,
  // Combinational read-back for checking
  input  logic [ADDR_WIDTH-1:0] peek_adr,
  output logic [DATA_WIDTH-1:0] peek_dat
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [DATA_WIDTH-1:0] mem [DEPTH];
  logic [31:0]           lfsr;
  logic [31:0]           lfsr_next;
  logic [1:0]            delay_draw;
  logic [1:0]            wait_left;
  logic                  busy;
  logic                  request;
  logic                  fire;

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    if (state[0]) begin
      return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
  endfunction

  // Two bits per access, 0 to 3 wait cycles
  assign lfsr_next  = lfsr_step(lfsr);
  assign delay_draw = {lfsr[0], lfsr_next[0]};
  assign peek_dat   = mem[peek_adr[IDX_W-1:0]];

  // New request, not the cycle of our own ack
  assign request = wb_cyc & wb_stb & ~wb_ack;
  assign fire    = request & (busy ? (wait_left == 2'd0) : (delay_draw == 2'd0));

  always_ff @(posedge ap_clk) begin
    if (load_en) begin
      mem[load_adr[IDX_W-1:0]] <= load_dat;
    end
    if (areset_control) begin
      wb_ack    <= 1'b0;
      busy      <= 1'b0;
      wait_left <= 2'd0;
      lfsr      <= SEED;
    end else begin
      wb_ack <= fire;
      if (request && !busy) begin
        // First cycle of an access, draw its delay
        lfsr      <= lfsr_step(lfsr_next);
        busy      <= (delay_draw != 2'd0);
        wait_left <= delay_draw - 2'd1;
      end else if (request) begin
        busy      <= (wait_left != 2'd0);
        wait_left <= wait_left - 2'd1;
      end
      if (fire) begin
        wb_dat_r <= mem[wb_adr[IDX_W-1:0]];
        if (wb_we) begin
          mem[wb_adr[IDX_W-1:0]] <= wb_dat_w;
        end
      end
    end
  end

endmodule : tb_wb_memory

// ==== vertex_reduce_engine.sv ====
// Vertex reduction engine
// Reads the vertex words in order, folds them by opcode, writes one result

`timescale 1ns/1ps

module vertex_reduce_engine #(
  parameter int ADDR_WIDTH = kernel_cu_pkg::DEFAULT_ADDR_WIDTH,
  parameter int DATA_WIDTH = kernel_cu_pkg::DEFAULT_DATA_WIDTH
) (
  input  logic                                   ap_clk,
  input  logic                                   areset_control,
  // Work from the setup reader
  input  logic                                   start,
  input  kernel_cu_pkg::reduce_op_e              op,
  input  logic [kernel_cu_pkg::COUNT_WIDTH-1:0]  count,
  input  logic [ADDR_WIDTH-1:0]                  vertex_addr,
  input  logic [ADDR_WIDTH-1:0]                  result_addr,
  // Memory port toward the arbiter
  output logic                                   eng_cyc,
  output logic                                   eng_stb,
  output logic                                   eng_we,
  output logic [ADDR_WIDTH-1:0]                  eng_adr,
  output logic [DATA_WIDTH-1:0]                  eng_dat_w,
  input  logic [DATA_WIDTH-1:0]                  eng_dat_r,
  input  logic                                   eng_ack,
  output logic                                   finished
);

  kernel_cu_pkg::engine_state_e          state;
  kernel_cu_pkg::reduce_op_e             op_q;
  logic [kernel_cu_pkg::COUNT_WIDTH-1:0] remaining;
  logic [ADDR_WIDTH-1:0]                 result_adr_q;
  logic [DATA_WIDTH-1:0]                 acc;
  logic [DATA_WIDTH-1:0]                 acc_next;
  logic                                  last_read;
  logic                                  launch;

  assign launch    = (state == kernel_cu_pkg::ENG_IDLE) & start;
  assign last_read = (remaining == kernel_cu_pkg::COUNT_WIDTH'(1));
  assign eng_stb   = eng_cyc;
  // Result word is the accumulator itself
  assign eng_dat_w = acc;
  assign finished  = (state == kernel_cu_pkg::ENG_DONE);

  // --------------------------------------------------------------------
  // Fold one vertex word into the accumulator
  // --------------------------------------------------------------------
  always_comb begin
    case (op_q)
      kernel_cu_pkg::OP_MAX:
        acc_next = (eng_dat_r > acc) ? eng_dat_r : acc;
      kernel_cu_pkg::OP_COUNT_NZ:
        acc_next = acc + DATA_WIDTH'(eng_dat_r != '0);
      // Sum wraps at the word width
      default:
        acc_next = acc + eng_dat_r;
    endcase
  end

  // Bus control and FSM
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      state   <= kernel_cu_pkg::ENG_IDLE;
      eng_cyc <= 1'b0;
      eng_we  <= 1'b0;
    end else begin
      case (state)
        kernel_cu_pkg::ENG_IDLE: begin
          if (start) begin
            eng_cyc <= 1'b1;
            if (count == '0) begin
              // Nothing to read, write zero straight away
              state  <= kernel_cu_pkg::ENG_WRITE;
              eng_we <= 1'b1;
            end else begin
              state <= kernel_cu_pkg::ENG_READ;
            end
          end
        end
        kernel_cu_pkg::ENG_READ: begin
          if (eng_ack && last_read) begin
            state  <= kernel_cu_pkg::ENG_WRITE;
            eng_we <= 1'b1;
          end
        end
        kernel_cu_pkg::ENG_WRITE: begin
          if (eng_ack) begin
            state   <= kernel_cu_pkg::ENG_DONE;
            eng_cyc <= 1'b0;
            eng_we  <= 1'b0;
          end
        end
        default: state <= kernel_cu_pkg::ENG_IDLE;
      endcase
    end
  end

  // Address walk, count and accumulator
  always_ff @(posedge ap_clk) begin
    if (launch) begin
      op_q         <= op;
      remaining    <= count;
      result_adr_q <= result_addr;
      acc          <= '0;
      eng_adr      <= (count == '0) ? result_addr : vertex_addr;
    end else if ((state == kernel_cu_pkg::ENG_READ) && eng_ack) begin
      acc       <= acc_next;
      remaining <= remaining - 1'b1;
      // Last word read, point at the result
      eng_adr   <= last_read ? result_adr_q : eng_adr + 1'b1;
    end
  end

  // Writes only ever carry the final result
  assert property (@(posedge ap_clk) disable iff (areset_control)
    eng_we |-> (state == kernel_cu_pkg::ENG_WRITE))
    else $error("engine write outside ENG_WRITE");

endmodule : vertex_reduce_engine
